/* Bender.yml */
package:
  name: ice_bus_controller

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ice_frame_pkg.sv
      - rtl/ice_dev_pkg.sv
      - rtl/priority_select.sv
      - rtl/ice_rx_parser.sv
      - rtl/ice_nak_gen.sv
      - rtl/ice_tx_mux.sv
      - rtl/ice_bus_controller.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/ice_clk_gen.sv
      - dv/ice_bus_controller_tb.sv

/* dv/ice_bus_controller_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ice_defs.svh"

module ice_bus_controller_tb import ice_frame_pkg::*; ();

	localparam int NUM_DEV = 2;
	localparam int NUM_ROWS = 8;
	localparam logic [`ICE_LEN_W-1:0] NO_OVF = '1;

	// One host frame plus the device bursts that run alongside it
	typedef struct packed {
		logic [7:0]            addr;
		logic [7:0]            evt_id;
		logic [`ICE_LEN_W-1:0] len;
		logic [`ICE_LEN_W-1:0] ovf_idx;
		logic [7:0]            d0_len;
		logic [7:0]            d0_base;
		logic [7:0]            d1_len;
		logic [7:0]            d1_base;
	} frame_vec_t;

	logic                    clk;
	logic                    byte_counter_reset;
	logic [7:0]              rx_char;
	logic                    rx_char_valid;
	logic [7:0]              tx_char;
	logic                    tx_char_valid;
	logic                    tx_char_ready;
	ma_bus_t                 ma;
	logic [NUM_DEV-1:0][7:0] sl_data;
	logic [NUM_DEV-1:0]      sl_arb_request;
	logic                    sl_overflow;
	logic [NUM_DEV-1:0]      sl_arb_grant;
	logic [NUM_DEV-1:0]      sl_data_latch;

	frame_vec_t vecs [NUM_ROWS];
	logic [7:0] dev0_q[$];
	logic [7:0] dev1_q[$];
	logic [7:0] tx_got[$];
	logic [7:0] rx_got[$];
	int         latch_cnt [NUM_DEV];
	integer     seed = 6429;

	ice_clk_gen u_clk_gen (
		.clk               (clk),
		.byte_counter_reset(byte_counter_reset)
	);

	ice_bus_controller #(.NUM_DEV(NUM_DEV)) u_dut (
		.clk               (clk),
		.byte_counter_reset(byte_counter_reset),
		.rx_char           (rx_char),
		.rx_char_valid     (rx_char_valid),
		.tx_char           (tx_char),
		.tx_char_valid     (tx_char_valid),
		.tx_char_ready     (tx_char_ready),
		.ma                (ma),
		.sl_data           (sl_data),
		.sl_arb_request    (sl_arb_request),
		.sl_overflow       (sl_overflow),
		.sl_arb_grant      (sl_arb_grant),
		.sl_data_latch     (sl_data_latch)
	);

	task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
			$display("test failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "run aborted");
	endtask

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	function automatic logic [7:0] payload_byte(input frame_vec_t v, input int i);
		return v.addr ^ v.evt_id ^ (i[7:0] * 8'd7);
	endfunction

	// Each device bids while its queue holds bytes and pops the head on its latch
	initial begin : device_models
		sl_data = '0;
		sl_arb_request = '0;
		forever begin
			@(posedge clk);
			if (sl_data_latch[0]) begin
				if (dev0_q.size() == 0)
					abort_run("Device 0 was latched with nothing left to send");
				void'(dev0_q.pop_front());
				latch_cnt[0]++;
			end
			if (sl_data_latch[1]) begin
				if (dev1_q.size() == 0)
					abort_run("Device 1 was latched with nothing left to send");
				void'(dev1_q.pop_front());
				latch_cnt[1]++;
			end
			#2;
			sl_arb_request[0] = (dev0_q.size() != 0);
			sl_arb_request[1] = (dev1_q.size() != 0);
			sl_data[0] = sl_arb_request[0] ? dev0_q[0] : 8'h00;
			sl_data[1] = sl_arb_request[1] ? dev1_q[0] : 8'h00;
		end
	end

	// Ready about three cycles in four
	initial begin : ready_driver
		tx_char_ready = 1'b0;
		forever begin
			tick();
			tx_char_ready = ($random(seed) & 3) != 0;
		end
	end

	initial begin : monitors
		forever begin
			@(posedge clk);
			if (!byte_counter_reset) begin
				if (!tx_char_ready)
					check_eq("tx_char_valid", tx_char_valid, 1'b0);
				if (tx_char_valid)
					tx_got.push_back(tx_char);
				if (ma.data_valid) begin
					check_eq("ma.frame_valid", ma.frame_valid, 1'b1);
					rx_got.push_back(ma.data);
				end
				check_eq("sl_data_latch without grant", sl_data_latch & ~sl_arb_grant, '0);
			end
		end
	end

	initial begin : watchdog
		int unsigned limit;
		limit = 200;
		@(negedge byte_counter_reset);
		for (int r = 0; r < NUM_ROWS; r++)
			limit += 20 * (4 + vecs[r].len + vecs[r].d0_len + vecs[r].d1_len +
				((vecs[r].ovf_idx != NO_OVF) ? 2 : 0));
		repeat (limit) @(posedge clk);
		abort_run($sformatf("Timeout, the table did not finish within %0d cycles", limit));
	end

	task automatic send_byte(input logic [7:0] b, input logic ovf, input logic exp_fv,
		input logic exp_dv);
		rx_char = b;
		rx_char_valid = 1'b1;
		sl_overflow = ovf;
		@(posedge clk);
		check_eq("ma.frame_valid", ma.frame_valid, exp_fv);
		check_eq("ma.data_valid", ma.data_valid, exp_dv);
		#2;
		rx_char_valid = 1'b0;
		sl_overflow = 1'b0;
	endtask

	task automatic run_row(input frame_vec_t v);
		logic [7:0] tx_exp[$];
		logic [7:0] rx_exp[$];
		logic       has_ovf;
		logic       kept;
		logic [7:0] pb;

		has_ovf = (v.ovf_idx != NO_OVF);
		// Device 0 wins the first bid and device 1 follows once it lets go
		for (int i = 0; i < v.d0_len; i++)
			tx_exp.push_back(v.d0_base + i[7:0]);
		for (int i = 0; i < v.d1_len; i++)
			tx_exp.push_back(v.d1_base + i[7:0]);
		if (has_ovf) begin
			tx_exp.push_back(`ICE_NAK_CODE);
			tx_exp.push_back(v.evt_id);
		end

		// Loaded on an edge so both devices start bidding in the same cycle
		@(posedge clk);
		latch_cnt[0] = 0;
		latch_cnt[1] = 0;
		for (int i = 0; i < v.d0_len; i++)
			dev0_q.push_back(v.d0_base + i[7:0]);
		for (int i = 0; i < v.d1_len; i++)
			dev1_q.push_back(v.d1_base + i[7:0]);
		#2;

		send_byte(v.addr, 1'b0, 1'b0, 1'b0);
		check_eq("ma.addr", ma.addr, v.addr);
		send_byte(v.evt_id, 1'b0, 1'b1, 1'b0);
		send_byte(v.len[15:8], 1'b0, 1'b1, 1'b0);
		send_byte(v.len[7:0], 1'b0, 1'b1, 1'b0);
		for (int i = 0; i < v.len; i++) begin
			// Idle gap now and then
			if (i % 4 == 3)
				tick();
			pb = payload_byte(v, i);
			kept = !has_ovf || i <= v.ovf_idx;
			if (kept)
				rx_exp.push_back(pb);
			send_byte(pb, has_ovf && i == v.ovf_idx, kept, kept);
		end

		// After an overflow the parser sits in DISCARD until the NAK handshake is idle
		while (u_dut.u_rx_parser.state != RX_IDLE)
			tick();
		@(posedge clk);
		check_eq("ma.frame_valid", ma.frame_valid, 1'b0);
		check_eq("ma.data_valid", ma.data_valid, 1'b0);
		#2;
		while (tx_got.size() < tx_exp.size())
			tick();

		check_eq("payload byte count", rx_got.size(), rx_exp.size());
		foreach (rx_exp[i])
			check_eq("ma.data", rx_got[i], rx_exp[i]);
		rx_got.delete();
		foreach (tx_exp[i])
			check_eq("tx_char", tx_got.pop_front(), tx_exp[i]);
		check_eq("sl_data_latch[0] count", latch_cnt[0], v.d0_len);
		check_eq("sl_data_latch[1] count", latch_cnt[1], v.d1_len);
	endtask

	initial begin : stimulus
		rx_char = 8'h00;
		rx_char_valid = 1'b0;
		sl_overflow = 1'b0;

		//         addr   evt_id  length   ovf_idx  dev0 len/base  dev1 len/base
		vecs[0] = {8'h11, 8'h21, 16'd4,   NO_OVF, 8'd3, 8'hA0, 8'd2, 8'hB0};
		vecs[1] = {8'h12, 8'h22, 16'd0,   NO_OVF, 8'd0, 8'h00, 8'd0, 8'h00};
		vecs[2] = {8'h13, 8'h23, 16'd5,   NO_OVF, 8'd0, 8'h00, 8'd0, 8'h00};
		vecs[3] = {8'h24, 8'h5A, 16'd6,   16'd2,  8'd0, 8'h00, 8'd0, 8'h00};
		vecs[4] = {8'h25, 8'h26, 16'd3,   NO_OVF, 8'd4, 8'h40, 8'd5, 8'h80};
		vecs[5] = {8'h30, 8'h6C, 16'd4,   16'd3,  8'd0, 8'h00, 8'd0, 8'h00};
		vecs[6] = {8'h31, 8'h32, 16'd259, NO_OVF, 8'd7, 8'hC0, 8'd6, 8'hD0};
		vecs[7] = {8'h42, 8'h77, 16'd5,   16'd0,  8'd0, 8'h00, 8'd6, 8'h10};

		@(posedge clk);
		while (byte_counter_reset)
			@(posedge clk);
		check_eq("tx_char_valid", tx_char_valid, 1'b0);
		check_eq("sl_arb_grant", sl_arb_grant, '0);
		check_eq("ma.frame_valid", ma.frame_valid, 1'b0);
		check_eq("ma.data_valid", ma.data_valid, 1'b0);
		#2;

		for (int r = 0; r < NUM_ROWS; r++)
			run_row(vecs[r]);

		repeat (10) tick();
		check_eq("extra tx bytes", tx_got.size(), 0);
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/ice_clk_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module ice_clk_gen #(
	parameter int PERIOD = 20,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic byte_counter_reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Released a little after the edge, like every other DUT input
	initial begin
		byte_counter_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#2 byte_counter_reset = 1'b0;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+rtl
rtl/ice_frame_pkg.sv
rtl/ice_dev_pkg.sv
rtl/priority_select.sv
rtl/ice_rx_parser.sv
rtl/ice_nak_gen.sv
rtl/ice_tx_mux.sv
rtl/ice_bus_controller.sv
dv/ice_clk_gen.sv
dv/ice_bus_controller_tb.sv

/* rtl/ice_bus_controller.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ice_defs.svh"

module ice_bus_controller
	import ice_frame_pkg::*;
	import ice_dev_pkg::*;
#(
	parameter int NUM_DEV = `ICE_NUM_DEV
) (
	input  wire logic                    clk,
	input  wire logic                    byte_counter_reset,
	input  wire logic [7:0]              rx_char,
	input  wire logic                    rx_char_valid,
	output logic      [7:0]              tx_char,
	output logic                         tx_char_valid,
	input  wire logic                    tx_char_ready,
	output ma_bus_t                      ma,
	input  wire logic [NUM_DEV-1:0][7:0] sl_data,
	input  wire logic [NUM_DEV-1:0]      sl_arb_request,
	input  wire logic                    sl_overflow,
	output logic      [NUM_DEV-1:0]      sl_arb_grant,
	output logic      [NUM_DEV-1:0]      sl_data_latch
);

	// Slot 0 is the NAK generator, devices follow
	localparam int NUM_SRC = NUM_DEV + 1;

	nak_req_t                   nak;
	logic                       nak_ack;
	tx_src_t                    nak_src;
	tx_src_t      [NUM_SRC-1:0] srcs;
	logic         [NUM_SRC-1:0] src_req;
	logic         [NUM_SRC-1:0] grants;
	logic         [NUM_SRC-1:0] latches;
	logic                       granted;

	ice_rx_parser u_rx_parser (
		.clk               (clk),
		.byte_counter_reset(byte_counter_reset),
		.rx_char           (rx_char),
		.rx_char_valid     (rx_char_valid),
		.sl_overflow       (sl_overflow),
		.nak_ack           (nak_ack),
		.ma                (ma),
		.nak               (nak)
	);

	ice_nak_gen u_nak_gen (
		.clk               (clk),
		.byte_counter_reset(byte_counter_reset),
		.nak               (nak),
		.latch             (latches[0]),
		.nak_ack           (nak_ack),
		.src               (nak_src)
	);

	always_comb begin
		srcs[0] = nak_src;
		for (int d = 0; d < NUM_DEV; d++) begin
			srcs[d+1].data = sl_data[d];
			srcs[d+1].req = sl_arb_request[d];
		end
		for (int s = 0; s < NUM_SRC; s++) begin
			src_req[s] = srcs[s].req;
		end
	end

	priority_select #(.NUM_REQ(NUM_SRC)) u_arb (
		.clk               (clk),
		.byte_counter_reset(byte_counter_reset),
		.requests          (src_req),
		.grants            (grants),
		.granted           (granted)
	);

	ice_tx_mux #(.NUM_SRC(NUM_SRC)) u_tx_mux (
		.srcs         (srcs),
		.grants       (grants),
		.granted      (granted),
		.tx_char_ready(tx_char_ready),
		.tx_char      (tx_char),
		.tx_char_valid(tx_char_valid),
		.latches      (latches)
	);

	assign sl_arb_grant = grants[NUM_SRC-1:1];
	assign sl_data_latch = latches[NUM_SRC-1:1];

endmodule

`default_nettype wire

/* rtl/ice_defs.svh */
`ifndef ICE_DEFS_SVH
`define ICE_DEFS_SVH

// Peer devices on the master bus, excluding the NAK generator
`define ICE_NUM_DEV 2

// Payload length field and byte counter width
`define ICE_LEN_W 16

// First byte of every NAK sent back to the host
`define ICE_NAK_CODE 8'h15

`endif

/* rtl/ice_dev_pkg.sv */
`default_nettype none

package ice_dev_pkg;

	// Four-phase request from the parser to the NAK generator
	// evt_id is held stable for as long as req is high
	typedef struct packed {
		logic       req;
		logic [7:0] evt_id;
	} nak_req_t;

	// One bidder on the shared transmit channel
	typedef struct packed {
		// Byte presented while granted
		logic [7:0] data;
		// Arbiter request, held until the last byte is latched
		logic       req;
	} tx_src_t;

endpackage

`default_nettype wire

/* rtl/ice_frame_pkg.sv */
`default_nettype none

package ice_frame_pkg;

	// Receive parser states
	// DISCARD drops the rest of a frame after a device overflow
	typedef enum logic [2:0] {
		RX_IDLE,
		RX_ID,
		RX_LEN,
		RX_PYLD,
		RX_DISCARD
	} rx_state_t;

	// Master bus seen by every peer device
	typedef struct packed {
		// Payload byte, only meaningful with data_valid
		logic [7:0] data;
		// Target address of the current frame
		logic [7:0] addr;
		logic       data_valid;
		// High from the event ID through the last payload byte
		logic       frame_valid;
	} ma_bus_t;

endpackage

`default_nettype wire

/* rtl/ice_nak_gen.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ice_defs.svh"

module ice_nak_gen import ice_dev_pkg::*; (
	input  wire logic     clk,
	input  wire logic     byte_counter_reset,
	input  wire nak_req_t nak,
	input  wire logic     latch,
	output logic          nak_ack,
	output tx_src_t       src
);

	logic       busy;
	logic       sel_id;
	logic [7:0] evt_q;

	always_ff @(posedge clk) begin
		if (byte_counter_reset) begin
			busy <= 1'b0;
			sel_id <= 1'b0;
			nak_ack <= 1'b0;
		end else if (busy) begin
			// Code byte first, then the event ID
			if (latch && !sel_id) begin
				sel_id <= 1'b1;
			end else if (latch) begin
				busy <= 1'b0;
				sel_id <= 1'b0;
				nak_ack <= 1'b1;
			end
		end else if (nak_ack) begin
			if (!nak.req)
				nak_ack <= 1'b0;
		end else if (nak.req) begin
			busy <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && !nak_ack && nak.req)
			evt_q <= nak.evt_id;
	end

	assign src.req = busy;
	assign src.data = sel_id ? evt_q : `ICE_NAK_CODE;

	// Holds across back-pressure and lost arbitration
	a_src_stable: assert property (
		@(posedge clk) disable iff (byte_counter_reset)
		src.req && !latch |=> src.req && $stable(src.data)
	);

endmodule

`default_nettype wire

/* rtl/ice_rx_parser.sv */
`timescale 1ns/1ns
`default_nettype none

`include "ice_defs.svh"

module ice_rx_parser
	import ice_frame_pkg::*;
	import ice_dev_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       byte_counter_reset,
	input  wire logic [7:0] rx_char,
	input  wire logic       rx_char_valid,
	input  wire logic       sl_overflow,
	input  wire logic       nak_ack,
	output ma_bus_t         ma,
	output nak_req_t        nak
);

	rx_state_t state;
	rx_state_t state_nxt;

	logic [`ICE_LEN_W-1:0] byte_cnt;
	logic [`ICE_LEN_W-1:0] pyld_len;
	logic [`ICE_LEN_W-1:0] len_next;
	logic [7:0]            addr_q;
	logic [7:0]            evt_q;
	logic                  nak_req_q;
	logic                  cnt_done;
	logic                  last_byte;

	// Length arrives big-endian, so shift in from the bottom
	assign len_next = {pyld_len[`ICE_LEN_W-9:0], rx_char};
	assign cnt_done = (byte_cnt == pyld_len);
	assign last_byte = (byte_cnt == pyld_len - 1'b1);

	always_comb begin
		state_nxt = state;
		case (state)
			RX_IDLE: begin
				if (rx_char_valid)
					state_nxt = RX_ID;
			end
			RX_ID: begin
				if (rx_char_valid)
					state_nxt = RX_LEN;
			end
			RX_LEN: begin
				// byte_cnt[0] marks the second length byte
				if (rx_char_valid && byte_cnt[0])
					state_nxt = (len_next == '0) ? RX_IDLE : RX_PYLD;
			end
			RX_PYLD: begin
				// Overflow wins over the end of the frame, a NAK is still owed
				if (sl_overflow)
					state_nxt = RX_DISCARD;
				else if (rx_char_valid && last_byte)
					state_nxt = RX_IDLE;
			end
			RX_DISCARD: begin
				if (cnt_done && !nak_req_q && !nak_ack)
					state_nxt = RX_IDLE;
			end
			default: state_nxt = RX_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (byte_counter_reset) begin
			state <= RX_IDLE;
			byte_cnt <= '0;
			nak_req_q <= 1'b0;
		end else begin
			state <= state_nxt;

			case (state)
				RX_LEN: begin
					if (rx_char_valid)
						byte_cnt <= byte_cnt[0] ? '0 : byte_cnt + 1'b1;
				end
				RX_PYLD, RX_DISCARD: begin
					// Discarded bytes still count toward the frame length
					if (rx_char_valid && !cnt_done)
						byte_cnt <= byte_cnt + 1'b1;
				end
				default: byte_cnt <= '0;
			endcase

			if (state == RX_PYLD && state_nxt == RX_DISCARD)
				nak_req_q <= 1'b1;
			else if (nak_ack)
				nak_req_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (state == RX_IDLE && rx_char_valid)
			addr_q <= rx_char;
		if (state == RX_ID && rx_char_valid)
			evt_q <= rx_char;
		if (state == RX_LEN && rx_char_valid)
			pyld_len <= len_next;
	end

	assign ma.addr = addr_q;
	assign ma.data = (state == RX_PYLD) ? rx_char : 8'h00;
	assign ma.data_valid = (state == RX_PYLD) && rx_char_valid;
	assign ma.frame_valid = (state == RX_ID && rx_char_valid) ||
		(state == RX_LEN) || (state == RX_PYLD);

	assign nak.req = nak_req_q;
	assign nak.evt_id = evt_q;

	a_req_until_ack: assert property (
		@(posedge clk) disable iff (byte_counter_reset)
		$fell(nak.req) |-> nak_ack
	);

endmodule

`default_nettype wire

/* rtl/ice_tx_mux.sv */
`timescale 1ns/1ns
`default_nettype none

module ice_tx_mux import ice_dev_pkg::*; #(
	parameter int NUM_SRC = 3
) (
	input  wire tx_src_t [NUM_SRC-1:0] srcs,
	input  wire logic    [NUM_SRC-1:0] grants,
	input  wire logic                  granted,
	input  wire logic                  tx_char_ready,
	output logic         [7:0]         tx_char,
	output logic                       tx_char_valid,
	output logic         [NUM_SRC-1:0] latches
);

	// AND-OR select, grants are one-hot or zero
	always_comb begin
		tx_char = 8'h00;
		for (int i = 0; i < NUM_SRC; i++) begin
			tx_char = tx_char | (srcs[i].data & {8{grants[i]}});
		end
	end

	// Transfer happens whenever a grant meets ready
	assign tx_char_valid = tx_char_ready & granted;

	// Owner advances on the same edge as its transfer
	assign latches = grants & {NUM_SRC{tx_char_valid}};

endmodule

`default_nettype wire

/* rtl/priority_select.sv */
`timescale 1ns/1ns
`default_nettype none

module priority_select #(
	parameter int NUM_REQ = 3
) (
	input  wire logic               clk,
	input  wire logic               byte_counter_reset,
	input  wire logic [NUM_REQ-1:0] requests,
	output logic      [NUM_REQ-1:0] grants,
	output logic                    granted
);

	logic [NUM_REQ-1:0] held;
	logic [NUM_REQ-1:0] pick;
	logic               hold_live;

	// Lowest index wins
	always_comb begin
		pick = '0;
		for (int i = NUM_REQ - 1; i >= 0; i--) begin
			if (requests[i]) begin
				pick = '0;
				pick[i] = 1'b1;
			end
		end
	end

	// Previous grant stays as long as its owner keeps requesting
	assign hold_live = |(held & requests);

	// A freed channel goes to the next bidder in the same cycle
	assign grants = hold_live ? held : pick;
	assign granted = |grants;

	always_ff @(posedge clk) begin
		if (byte_counter_reset) begin
			held <= '0;
		end else begin
			held <= grants;
		end
	end

	a_grant_onehot: assert property (
		@(posedge clk) disable iff (byte_counter_reset)
		$onehot0(grants)
	);

	// No pre-emption, even by a higher priority bidder
	for (genvar g = 0; g < NUM_REQ; g++) begin : g_hold_chk
		a_grant_held: assert property (
			@(posedge clk) disable iff (byte_counter_reset)
			grants[g] && requests[g] |=> grants[g] || !requests[g]
		);
	end

endmodule

`default_nettype wire
